// File: tb.f
+incdir+include
logic/tomasulo_pkg.sv
logic/issue_unit.sv
logic/res_station_bank.sv
logic/exec_unit.sv
logic/tomasulo_core.sv
dv/tb_top.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_top
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// op numbering local to the bench
localparam int M_ADD = 0;
localparam int M_SUB = 1;
localparam int M_AND = 2;
localparam int M_OR  = 3;
localparam int M_XOR = 4;
localparam int M_SLL = 5;
localparam int M_SRL = 6;
localparam int M_SLT = 7;

// one lcg step, full 32-bit period
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// rv32i OP / OP-IMM encoding
function automatic logic [31:0] encode_instr(input int op, input bit imm_form,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [11:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    case (op)
        M_SLL:   f3 = 3'b001;
        M_SLT:   f3 = 3'b010;
        M_XOR:   f3 = 3'b100;
        M_SRL:   f3 = 3'b101;
        M_OR:    f3 = 3'b110;
        M_AND:   f3 = 3'b111;
        default: f3 = 3'b000;
    endcase
    f7 = (op == M_SUB) ? 7'b0100000 : 7'b0000000;
    // immediate shifts carry shamt with a zero funct7
    if (imm_form && (op == M_SLL || op == M_SRL)) begin
        return {7'b0000000, imm[4:0], rs1, f3, rd, 7'b0010011};
    end
    if (imm_form) begin
        return {imm, rs1, f3, rd, 7'b0010011};
    end
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// architectural result per the isa
function automatic logic [31:0] model_result(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
        M_ADD:   return a + b;
        M_SUB:   return a - b;
        M_AND:   return a & b;
        M_OR:    return a | b;
        M_XOR:   return a ^ b;
        M_SLL:   return a << b[4:0];
        M_SRL:   return a >> b[4:0];
        default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
endfunction

// mirrors the rename pool, lowest free tag first
function automatic logic [2:0] lowest_free_tag(input logic [7:0] held);
    for (int t = 0; t < 8; t++) begin
        if (!held[t]) begin
            return 3'(t);
        end
    end
    return 3'd0;
endfunction

`endif

// File: dv/tb_top.sv
`default_nettype none

module tb_top;

    localparam int NUM_RS     = 4;
    localparam int PROG_LEN   = 400;
    localparam int MAX_CYCLES = PROG_LEN * 12 + 200;
    localparam logic [31:0] SEED = 32'hf3bd;

    `include "tb_model.svh"

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [4:0]  dbg_addr;
    logic        issue_ready;
    logic        cdb_valid;
    logic [2:0]  cdb_tag;
    logic [4:0]  cdb_rd;
    logic [31:0] cdb_data;
    logic [31:0] dbg_data;

    // in-order register values, x0 to x7
    logic [31:0] model_regs [8];
    // expectation per outstanding tag
    logic [31:0] exp_data [8];
    logic [4:0]  exp_rd [8];
    int          issue_edge [8];
    logic [7:0]  tag_held;
    // tag on the bus now, freed at the coming edge
    logic [7:0]  release_mask;
    logic        bus_hit;
    logic [31:0] rng;
    int          cyc;
    int          value_errs;
    int          other_errs;
    int          stalls;
    int          retired;

    tomasulo_core #(
        .NUM_RS(NUM_RS)
    ) tomasulo_core_inst (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .dbg_addr(dbg_addr),
        .issue_ready(issue_ready),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_rd(cdb_rd),
        .cdb_data(cdb_data),
        .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // edge counter, also the run limit
    initial begin
        cyc = 0;
        while (cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        $display("timeout after %0d cycles, the program did not drain", cyc);
        $display("TESTS FAILED");
        $finish;
    end

    // match a broadcast to its outstanding instruction
    task automatic observe_bus();
        bus_hit = 1'b0;
        if (cdb_valid) begin
            if (!tag_held[cdb_tag]) begin
                other_errs++;
                $display("broadcast on tag %0d at edge %0d with nothing outstanding",
                         cdb_tag, cyc);
            end else begin
                bus_hit = 1'b1;
                retired++;
                release_mask[cdb_tag] = 1'b1;
                if (cdb_rd !== exp_rd[cdb_tag]) begin
                    value_errs++;
                    $display("Fail cdb_rd (tag %0d): got %h, expected %h",
                             cdb_tag, cdb_rd, exp_rd[cdb_tag]);
                end
                if (cdb_data !== exp_data[cdb_tag]) begin
                    value_errs++;
                    $display("Fail cdb_data (tag %0d): got %h, expected %h",
                             cdb_tag, cdb_data, exp_data[cdb_tag]);
                end
                if (cyc < issue_edge[cdb_tag] + 2) begin
                    other_errs++;
                    $display("tag %0d broadcast at edge %0d, under two edges after its strobe",
                             cdb_tag, cyc);
                end
            end
        end
    endtask

    // stations held = tags held minus the one already on the bus
    task automatic check_ready();
        int   held;
        int   in_rs;
        logic expect_ready;
        held         = $countones(tag_held);
        in_rs        = held - (bus_hit ? 1 : 0);
        expect_ready = (in_rs < NUM_RS) && (held < 8);
        if (issue_ready !== expect_ready) begin
            value_errs++;
            $display("Fail issue_ready at edge %0d: got %h, expected %h",
                     cyc, issue_ready, expect_ready);
        end
        if (!issue_ready) begin
            stalls++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        tag_held     = tag_held & ~release_mask;
        release_mask = '0;
        observe_bus();
        check_ready();
    endtask

    // waits for room, updates the model, strobes for one cycle
    task automatic issue_one(input int op, input bit imm_form, input logic [2:0] rd,
                             input logic [2:0] rs1, input logic [2:0] rs2,
                             input logic [11:0] imm);
        logic [2:0]  t;
        logic [31:0] b;
        while (issue_ready !== 1'b1) begin
            next_cycle();
        end
        t = lowest_free_tag(tag_held);
        if (!imm_form) begin
            b = model_regs[rs2];
        end else if (op == M_SLL || op == M_SRL) begin
            b = {27'b0, imm[4:0]};
        end else begin
            b = {{20{imm[11]}}, imm};
        end
        exp_data[t]   = model_result(op, model_regs[rs1], b);
        exp_rd[t]     = {2'b00, rd};
        issue_edge[t] = cyc + 1;
        tag_held[t]   = 1'b1;
        if (rd != 3'd0) begin
            model_regs[rd] = exp_data[t];
        end
        instr       = encode_instr(op, imm_form, {2'b00, rd}, {2'b00, rs1}, {2'b00, rs2}, imm);
        instr_valid = 1'b1;
        next_cycle();
        instr_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] w1;
        logic [31:0] w2;
        int          op;
        bit          imm_form;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [2:0]  prev_rd;
        int          gap;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        dbg_addr     = '0;
        tag_held     = '0;
        release_mask = '0;
        bus_hit      = 1'b0;
        rng          = SEED;
        value_errs   = 0;
        other_errs   = 0;
        stalls       = 0;
        retired      = 0;
        prev_rd      = 3'd0;
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        // quiet bus and ready high before any strobe
        repeat (4) next_cycle();
        for (int n = 0; n < PROG_LEN; n++) begin
            rng      = lcg_step(rng);
            w1       = rng;
            rng      = lcg_step(rng);
            w2       = rng;
            op       = int'(w1[30:28]);
            imm_form = w1[27];
            rd       = w1[26:24];
            rs1      = w1[23:21];
            rs2      = w1[20:18];
            // no subi in rv32i
            if (imm_form && op == M_SUB) begin
                op = M_ADD;
            end
            // bursts of back-to-back dependent strobes, then sparse phases
            if ((n / 50) % 2 == 0) begin
                rs1 = prev_rd;
                gap = 0;
            end else begin
                gap = int'(w2[17:16]);
            end
            issue_one(op, imm_form, rd, rs1, rs2, w2[31:20]);
            prev_rd = rd;
            repeat (gap) next_cycle();
        end
        // drain, then let the last writeback land
        while (tag_held != '0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
        for (int r = 0; r < 8; r++) begin
            dbg_addr = 5'(r);
            next_cycle();
            if (dbg_data !== model_regs[r]) begin
                value_errs++;
                $display("Fail dbg_data (x%0d): got %h, expected %h", r, dbg_data, model_regs[r]);
            end
        end
        if (retired != PROG_LEN) begin
            other_errs++;
            $display("only %0d of %0d instructions were broadcast", retired, PROG_LEN);
        end
        if (stalls == 0) begin
            other_errs++;
            $display("issue_ready never went low during the dependent bursts");
        end
        $display("value errors %0d, other errors %0d, stall cycles %0d",
                 value_errs, other_errs, stalls);
        if (value_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/tomasulo_core.sv
`default_nettype none

module tomasulo_core #(
    parameter int NUM_RS = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              instr_valid,
    input  logic [31:0]                       instr,
    input  logic [tomasulo_pkg::REG_W-1:0]    dbg_addr,
    output logic                              issue_ready,
    output logic                              cdb_valid,
    output logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
    output logic [tomasulo_pkg::REG_W-1:0]    cdb_rd,
    output logic [tomasulo_pkg::DATA_W-1:0]   cdb_data,
    output logic [tomasulo_pkg::DATA_W-1:0]   dbg_data
);
    import tomasulo_pkg::*;

    localparam int SLOT_W = $clog2(NUM_RS);

    // issue to stations
    logic              alloc_valid;
    logic [SLOT_W-1:0] alloc_slot;
    alu_op_t           alloc_op;
    logic [TAG_W-1:0]  alloc_tag;
    logic [REG_W-1:0]  alloc_rd;
    logic              alloc_src1_valid;
    logic [TAG_W-1:0]  alloc_src1_tag;
    logic [DATA_W-1:0] alloc_src1_data;
    logic              alloc_src2_valid;
    logic [TAG_W-1:0]  alloc_src2_tag;
    logic [DATA_W-1:0] alloc_src2_data;
    logic [NUM_RS-1:0] rs_free;

    // stations to execute
    logic              grant_valid;
    logic [SLOT_W-1:0] grant_slot;
    logic [NUM_RS-1:0] rs_ready;
    alu_op_t           sel_op;
    logic [TAG_W-1:0]  sel_tag;
    logic [REG_W-1:0]  sel_rd;
    logic [DATA_W-1:0] sel_a;
    logic [DATA_W-1:0] sel_b;

    issue_unit #(
        .NUM_RS(NUM_RS)
    ) issue_unit_inst (
        .*
    );

    res_station_bank #(
        .NUM_RS(NUM_RS)
    ) res_station_bank_inst (
        .*
    );

    exec_unit #(
        .NUM_RS(NUM_RS)
    ) exec_unit_inst (
        .*
    );

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`default_nettype none

module exec_unit #(
    parameter int NUM_RS = 4,
    localparam int SLOT_W = $clog2(NUM_RS)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [NUM_RS-1:0]                 rs_ready,
    input  tomasulo_pkg::alu_op_t             sel_op,
    input  logic [tomasulo_pkg::TAG_W-1:0]    sel_tag,
    input  logic [tomasulo_pkg::REG_W-1:0]    sel_rd,
    input  logic [tomasulo_pkg::DATA_W-1:0]   sel_a,
    input  logic [tomasulo_pkg::DATA_W-1:0]   sel_b,
    output logic                              grant_valid,
    output logic [SLOT_W-1:0]                 grant_slot,
    output logic                              cdb_valid,
    output logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
    output logic [tomasulo_pkg::REG_W-1:0]    cdb_rd,
    output logic [tomasulo_pkg::DATA_W-1:0]   cdb_data
);
    import tomasulo_pkg::*;

    logic [DATA_W-1:0] alu_res;

    // lowest ready station wins
    always_comb begin
        grant_slot = '0;
        for (int s = NUM_RS - 1; s >= 0; s--) begin
            if (rs_ready[s]) begin
                grant_slot = SLOT_W'(s);
            end
        end
    end

    assign grant_valid = |rs_ready;

    // shifts by low five bits, slt signed
    always_comb begin
        case (sel_op)
            OP_ADD:  alu_res = sel_a + sel_b;
            OP_SUB:  alu_res = sel_a - sel_b;
            OP_AND:  alu_res = sel_a & sel_b;
            OP_OR:   alu_res = sel_a | sel_b;
            OP_XOR:  alu_res = sel_a ^ sel_b;
            OP_SLL:  alu_res = sel_a << sel_b[4:0];
            OP_SRL:  alu_res = sel_a >> sel_b[4:0];
            OP_SLT:  alu_res = {{(DATA_W-1){1'b0}}, $signed(sel_a) < $signed(sel_b)};
            default: alu_res = '0;
        endcase
    end

    // bus valid
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= grant_valid;
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            cdb_tag  <= sel_tag;
            cdb_rd   <= sel_rd;
            cdb_data <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: logic/res_station_bank.sv
`default_nettype none

module res_station_bank #(
    parameter int NUM_RS = 4,
    localparam int SLOT_W = $clog2(NUM_RS)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc_valid,
    input  logic [SLOT_W-1:0]                 alloc_slot,
    input  tomasulo_pkg::alu_op_t             alloc_op,
    input  logic [tomasulo_pkg::TAG_W-1:0]    alloc_tag,
    input  logic [tomasulo_pkg::REG_W-1:0]    alloc_rd,
    input  logic                              alloc_src1_valid,
    input  logic [tomasulo_pkg::TAG_W-1:0]    alloc_src1_tag,
    input  logic [tomasulo_pkg::DATA_W-1:0]   alloc_src1_data,
    input  logic                              alloc_src2_valid,
    input  logic [tomasulo_pkg::TAG_W-1:0]    alloc_src2_tag,
    input  logic [tomasulo_pkg::DATA_W-1:0]   alloc_src2_data,
    input  logic                              grant_valid,
    input  logic [SLOT_W-1:0]                 grant_slot,
    input  logic                              cdb_valid,
    input  logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
    input  logic [tomasulo_pkg::DATA_W-1:0]   cdb_data,
    output logic [NUM_RS-1:0]                 rs_free,
    output logic [NUM_RS-1:0]                 rs_ready,
    output tomasulo_pkg::alu_op_t             sel_op,
    output logic [tomasulo_pkg::TAG_W-1:0]    sel_tag,
    output logic [tomasulo_pkg::REG_W-1:0]    sel_rd,
    output logic [tomasulo_pkg::DATA_W-1:0]   sel_a,
    output logic [tomasulo_pkg::DATA_W-1:0]   sel_b
);
    import tomasulo_pkg::*;

    // per-entry state
    logic              busy  [NUM_RS];
    alu_op_t           op    [NUM_RS];
    logic [TAG_W-1:0]  tag   [NUM_RS];
    logic [REG_W-1:0]  rd    [NUM_RS];
    logic [DATA_W-1:0] a     [NUM_RS];
    logic              a_vld [NUM_RS];
    logic [TAG_W-1:0]  a_tag [NUM_RS];
    logic [DATA_W-1:0] b     [NUM_RS];
    logic              b_vld [NUM_RS];
    logic [TAG_W-1:0]  b_tag [NUM_RS];

    // producer hitting the bus while the allocation is in flight
    logic alloc_a_hit;
    logic alloc_b_hit;

    assign alloc_a_hit = !alloc_src1_valid && cdb_valid && cdb_tag == alloc_src1_tag;
    assign alloc_b_hit = !alloc_src2_valid && cdb_valid && cdb_tag == alloc_src2_tag;

    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            rs_free[i]  = !busy[i];
            rs_ready[i] = busy[i] && a_vld[i] && b_vld[i];
        end
    end

    // granted entry out to the alu
    assign sel_op  = op[grant_slot];
    assign sel_tag = tag[grant_slot];
    assign sel_rd  = rd[grant_slot];
    assign sel_a   = a[grant_slot];
    assign sel_b   = b[grant_slot];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_RS; i++) begin
                busy[i]  <= 1'b0;
                a_vld[i] <= 1'b0;
                b_vld[i] <= 1'b0;
            end
        end else begin
            // snoop the bus for waiting operands
            for (int i = 0; i < NUM_RS; i++) begin
                if (busy[i] && cdb_valid && !a_vld[i] && a_tag[i] == cdb_tag) begin
                    a[i]     <= cdb_data;
                    a_vld[i] <= 1'b1;
                end
                if (busy[i] && cdb_valid && !b_vld[i] && b_tag[i] == cdb_tag) begin
                    b[i]     <= cdb_data;
                    b_vld[i] <= 1'b1;
                end
            end
            // granted entry frees at the edge it goes to the alu
            if (grant_valid) begin
                busy[grant_slot] <= 1'b0;
            end
            // new entry; its slot was free so no clash with the above
            if (alloc_valid) begin
                busy[alloc_slot]  <= 1'b1;
                op[alloc_slot]    <= alloc_op;
                tag[alloc_slot]   <= alloc_tag;
                rd[alloc_slot]    <= alloc_rd;
                a[alloc_slot]     <= alloc_a_hit ? cdb_data : alloc_src1_data;
                a_vld[alloc_slot] <= alloc_src1_valid || alloc_a_hit;
                a_tag[alloc_slot] <= alloc_src1_tag;
                b[alloc_slot]     <= alloc_b_hit ? cdb_data : alloc_src2_data;
                b_vld[alloc_slot] <= alloc_src2_valid || alloc_b_hit;
                b_tag[alloc_slot] <= alloc_src2_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_unit.sv
`default_nettype none

module issue_unit #(
    parameter int NUM_RS = 4,
    localparam int SLOT_W = $clog2(NUM_RS)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              instr_valid,
    input  logic [31:0]                       instr,
    input  logic [NUM_RS-1:0]                 rs_free,
    input  logic                              cdb_valid,
    input  logic [tomasulo_pkg::TAG_W-1:0]    cdb_tag,
    input  logic [tomasulo_pkg::REG_W-1:0]    cdb_rd,
    input  logic [tomasulo_pkg::DATA_W-1:0]   cdb_data,
    input  logic [tomasulo_pkg::REG_W-1:0]    dbg_addr,
    output logic                              issue_ready,
    output logic                              alloc_valid,
    output logic [SLOT_W-1:0]                 alloc_slot,
    output tomasulo_pkg::alu_op_t             alloc_op,
    output logic [tomasulo_pkg::TAG_W-1:0]    alloc_tag,
    output logic [tomasulo_pkg::REG_W-1:0]    alloc_rd,
    output logic                              alloc_src1_valid,
    output logic [tomasulo_pkg::TAG_W-1:0]    alloc_src1_tag,
    output logic [tomasulo_pkg::DATA_W-1:0]   alloc_src1_data,
    output logic                              alloc_src2_valid,
    output logic [tomasulo_pkg::TAG_W-1:0]    alloc_src2_tag,
    output logic [tomasulo_pkg::DATA_W-1:0]   alloc_src2_data,
    output logic [tomasulo_pkg::DATA_W-1:0]   dbg_data
);
    import tomasulo_pkg::*;

    localparam int NUM_REGS = 2 ** REG_W;

    // tagged register file
    logic [DATA_W-1:0] reg_data [NUM_REGS];
    logic              reg_pend [NUM_REGS];
    logic [TAG_W-1:0]  reg_tag  [NUM_REGS];
    logic [NUM_TAGS-1:0] tag_busy;

    // instruction fields
    logic [6:0]       opcode;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] src_idx [2];

    logic              is_imm;
    logic              dec_ok;
    alu_op_t           dec_op;
    logic [DATA_W-1:0] imm_val;

    logic              src_vld [2];
    logic [TAG_W-1:0]  src_tag [2];
    logic [DATA_W-1:0] src_dat [2];

    logic [NUM_RS-1:0] pend_slot;
    logic [NUM_RS-1:0] free_slots;
    logic [SLOT_W-1:0] new_slot;
    logic [TAG_W-1:0]  new_tag;
    logic              accept;

    assign opcode     = instr[6:0];
    assign f3         = instr[F3_LSB +: 3];
    assign f7         = instr[F7_LSB +: 7];
    assign rd         = instr[RD_LSB +: REG_W];
    assign src_idx[0] = instr[RS1_LSB +: REG_W];
    assign src_idx[1] = instr[RS2_LSB +: REG_W];
    assign is_imm     = (opcode == OPC_OPIMM);

    // decode, anything outside OP / OP-IMM subset gets dropped
    always_comb begin
        dec_ok = 1'b0;
        dec_op = OP_ADD;
        if (opcode == OPC_OP || is_imm) begin
            dec_ok = 1'b1;
            case (f3)
                F3_ADD: dec_op = (!is_imm && f7 == F7_ALT) ? OP_SUB : OP_ADD;
                F3_SLL: dec_op = OP_SLL;
                F3_SLT: dec_op = OP_SLT;
                F3_XOR: dec_op = OP_XOR;
                F3_SR:  dec_op = OP_SRL;
                F3_OR:  dec_op = OP_OR;
                F3_AND: dec_op = OP_AND;
                default: dec_ok = 1'b0;
            endcase
            // funct7 must be zero for register forms and immediate shifts, sub aside
            if ((!is_imm || f3 == F3_SLL || f3 == F3_SR) && f7 != 7'b0 &&
                !(!is_imm && f3 == F3_ADD && f7 == F7_ALT)) begin
                dec_ok = 1'b0;
            end
        end
    end

    // shamt zero extended, other immediates sign extended
    assign imm_val = (f3 == F3_SLL || f3 == F3_SR) ?
                     {{(DATA_W-5){1'b0}}, instr[IMM_LSB +: 5]} :
                     {{(DATA_W-12){instr[31]}}, instr[IMM_LSB +: 12]};

    // operand read, with bypass when the producer is on the bus now
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_vld[i] = 1'b1;
            src_tag[i] = reg_tag[src_idx[i]];
            src_dat[i] = reg_data[src_idx[i]];
            if (reg_pend[src_idx[i]]) begin
                if (cdb_valid && cdb_tag == reg_tag[src_idx[i]]) begin
                    src_dat[i] = cdb_data;
                end else begin
                    src_vld[i] = 1'b0;
                end
            end
        end
        if (is_imm) begin
            src_vld[1] = 1'b1;
            src_dat[1] = imm_val;
        end
    end

    // slot held by the allocation still in flight to the stations
    assign pend_slot  = alloc_valid ? (NUM_RS'(1) << alloc_slot) : '0;
    assign free_slots = rs_free & ~pend_slot;

    // lowest free station and lowest free tag
    always_comb begin
        new_slot = '0;
        for (int s = NUM_RS - 1; s >= 0; s--) begin
            if (free_slots[s]) begin
                new_slot = SLOT_W'(s);
            end
        end
        new_tag = '0;
        for (int t = NUM_TAGS - 1; t >= 0; t--) begin
            if (!tag_busy[t]) begin
                new_tag = TAG_W'(t);
            end
        end
    end

    assign issue_ready = (|free_slots) && !(&tag_busy);
    assign accept      = instr_valid && issue_ready && dec_ok;
    assign dbg_data    = reg_data[dbg_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_valid <= 1'b0;
            tag_busy    <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                reg_data[r] <= '0;
                reg_pend[r] <= 1'b0;
                reg_tag[r]  <= '0;
            end
        end else begin
            alloc_valid <= accept;
            // writeback only from the latest producer of the register
            if (cdb_valid) begin
                tag_busy[cdb_tag] <= 1'b0;
                if (reg_pend[cdb_rd] && reg_tag[cdb_rd] == cdb_tag) begin
                    reg_data[cdb_rd] <= cdb_data;
                    reg_pend[cdb_rd] <= 1'b0;
                end
            end
            // retag overrides a same-cycle writeback; x0 stays untagged
            if (accept) begin
                tag_busy[new_tag] <= 1'b1;
                if (rd != '0) begin
                    reg_pend[rd] <= 1'b1;
                    reg_tag[rd]  <= new_tag;
                end
            end
        end
    end

    // allocation payload, one cycle behind the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            alloc_slot       <= new_slot;
            alloc_op         <= dec_op;
            alloc_tag        <= new_tag;
            alloc_rd         <= rd;
            alloc_src1_valid <= src_vld[0];
            alloc_src1_tag   <= src_tag[0];
            alloc_src1_data  <= src_dat[0];
            alloc_src2_valid <= src_vld[1];
            alloc_src2_tag   <= src_tag[1];
            alloc_src2_data  <= src_dat[1];
        end
    end

endmodule

`default_nettype wire

// File: logic/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    // datapath and rename widths
    localparam int DATA_W   = 32;
    localparam int TAG_W    = 3;
    localparam int NUM_TAGS = 8;
    localparam int REG_W    = 5;

    // alu operations carried through the stations
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT
    } alu_op_t;

    // rv32i major opcodes handled here
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

    // instruction field positions
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int IMM_LSB = 20;
    localparam int F7_LSB  = 25;

    // funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 of sub (and of sra, which is not taken)
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

`default_nettype wire
